// ==== vlog.f ====
common/mbu_pkg.sv
hw/mbu_decode.sv
mbu/mbu_bank_file.sv
mbu/mbu_context.sv
hw/mbu_output_mux.sv
hw/mbu_top.sv
sim/mbu_tb.sv

// ==== sim/mbu_tb.sv ====
//////////////////////////////
// Shadow model of mbu_top compared every cycle, CTX_BITS fixed at 3
// All 64 banks are written before any random read
//////////////////////////////

`timescale 1ns/1ns

module mbu_tb;

   import mbu_pkg::*;

   localparam int    CTX_BITS    = 3;
   localparam int    TEST_CYCLES = 650;       // Upper bound over all tests
   localparam int    CLK_PERIOD  = 8;
   localparam unit_t IDLE        = 5'b00000;  // No MBU unit, no AR write

   // Expected outputs for one cycle
   typedef struct packed {
      logic  oe;
      word_t out;
      word_t aext;
      logic  war;
   } predict_t;

   logic      clk;
   logic      reset;
   unit_t     raddr;
   unit_t     waddr;
   bank_idx_t ir;
   logic      ir_idx;
   word_t     ibus_in;
   logic      ram_rom;
   word_t     ibus_out;
   logic      ibus_oe;
   word_t     aext;
   logic      war;

   integer seed        = 32'h14be;
   int     error_count = 0;
   logic   checking    = 1'b0;     // Compare only after reset

   // Shadow model
   word_t m_mem [(2 ** CTX_BITS) * NUM_BANKS];
   word_t m_ctx;
   logic  m_enabled;
   word_t m_aext;

   mbu_top #(.CTX_BITS(CTX_BITS)) UUT (
      .clk (clk), .reset (reset), .raddr (raddr), .waddr (waddr),
      .ir (ir), .ir_idx (ir_idx), .ibus_in (ibus_in), .ram_rom (ram_rom),
      .ibus_out (ibus_out), .ibus_oe (ibus_oe), .aext (aext), .war (war)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // MBP access on either side means bank 0
   function automatic bank_idx_t bus_bank();
      if (raddr == UNIT_MBP || waddr == UNIT_MBP) begin
         return '0;
      end
      return ir;
   endfunction

   function automatic bank_idx_t ar_bank();
      if (ir_idx) begin
         return ir;
      end
      return {1'b0, waddr[1:0]};     // Banks 0..3 only
   endfunction

   function automatic int mem_addr(input word_t c, input bank_idx_t b);
      return {c[CTX_BITS-1:0], b};   // High ctx bits ignored
   endfunction

   function automatic predict_t predict_outputs();
      predict_t p;
      p      = '0;
      p.war  = (waddr[4:2] == AR_WRITE_PREFIX);
      p.aext = m_aext;               // Registered, from the model
      if (raddr == UNIT_CTX_A || raddr == UNIT_CTX_B) begin
         p.oe  = 1'b1;
         p.out = m_ctx;
      end else if (raddr == UNIT_MBN || raddr == UNIT_MBP) begin
         p.oe  = 1'b1;
         p.out = m_mem[mem_addr(m_ctx, bus_bank())];
      end
      return p;
   endfunction

   // Inputs change 1 ns after the edge, so they are settled here
   always @(posedge clk) begin : model_update
      word_t dflt;
      dflt = {ram_rom, 7'b0};
      if (reset) begin
         m_ctx     = '0;
         m_enabled = 1'b0;
         m_aext    = dflt;
      end else begin
         if (!m_enabled) begin
            m_aext = dflt;
         end else if (waddr[4:2] == AR_WRITE_PREFIX) begin
            m_aext = m_mem[mem_addr(m_ctx, ar_bank())];  // Old ctx and banks
         end
         if (waddr == UNIT_MBN || waddr == UNIT_MBP) begin
            m_mem[mem_addr(m_ctx, bus_bank())] = ibus_in;
            m_enabled = 1'b1;
         end
         if (waddr == UNIT_CTX_A || waddr == UNIT_CTX_B) begin
            m_ctx = ibus_in;
         end
      end
   end

   //////////////////////////////
   // Compare, mid cycle
   //////////////////////////////

   always @(negedge clk) begin : compare
      predict_t want;
      want = predict_outputs();
      if (checking) begin
         if (ibus_oe !== want.oe) begin
            $display("FAIL t=%0t ibus_oe expected %b got %b", $time, want.oe, ibus_oe);
            error_count++;
         end
         if (ibus_out !== want.out) begin
            $display("FAIL t=%0t ibus_out expected %h got %h", $time, want.out, ibus_out);
            error_count++;
         end
         if (aext !== want.aext) begin
            $display("FAIL t=%0t aext expected %h got %h", $time, want.aext, aext);
            error_count++;
         end
         if (war !== want.war) begin
            $display("FAIL t=%0t war expected %b got %b", $time, want.war, war);
            error_count++;
         end
      end
   end

   //////////////////////////////
   // Stimulus helpers
   //////////////////////////////

   task automatic drive(input unit_t r, input unit_t w, input bank_idx_t i,
                        input logic ii, input word_t d);
      @(posedge clk);
      #1;
      raddr   = r;
      waddr   = w;
      ir      = i;
      ir_idx  = ii;
      ibus_in = d;
   endtask

   task automatic drive_idle();
      drive(IDLE, IDLE, '0, 1'b0, '0);
   endtask

   task automatic check_word(input string name, input word_t want, input word_t got);
      if (got !== want) begin
         $display("FAIL t=%0t %s expected %h got %h", $time, name, want, got);
         error_count++;
      end
   endtask

   task automatic read_and_check(input unit_t r, input bank_idx_t i, input word_t want);
      drive(r, IDLE, i, 1'b0, '0);
      @(negedge clk);
      check_word("ibus_out", want, ibus_out);
   endtask

   task automatic aext_after(input word_t want);
      drive_idle();
      @(negedge clk);
      check_word("aext", want, aext);
   endtask

   // Odd multiplier, unique per {context, bank}
   function automatic word_t bank_fill(input int c, input int b);
      return 8'((c * 8 + b) * 29 + 8'h47);
   endfunction

   function automatic unit_t pick_unit(input logic [31:0] r);
      case (r[2:0])
         3'd1:    return UNIT_MBN;
         3'd2:    return UNIT_MBP;
         3'd3:    return UNIT_CTX_A;
         3'd4:    return UNIT_CTX_B;
         3'd5:    return {AR_WRITE_PREFIX, r[4:3]};
         3'd6:    return 5'b10110;   // Foreign unit
         3'd7:    return 5'b11111;
         default: return IDLE;
      endcase
   endfunction

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin
      int c;
      int b;
      int n;
      reset   = 1'b1;
      raddr   = IDLE;
      waddr   = IDLE;
      ir      = '0;
      ir_idx  = 1'b0;
      ibus_in = '0;
      ram_rom = 1'b0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      checking = 1'b1;

      // Default aext for both switch positions, foreign reads
      drive(5'b00101, IDLE, '0, 1'b0, '0);
      @(negedge clk);
      check_word("aext", 8'h00, aext);
      ram_rom = 1'b1;
      drive(5'b11111, IDLE, '0, 1'b0, '0);
      aext_after(8'h80);

      // AR write while disabled, then enable
      drive(IDLE, {AR_WRITE_PREFIX, 2'b10}, '0, 1'b0, '0);
      aext_after(8'h80);
      drive(IDLE, UNIT_MBN, 3'd3, 1'b0, 8'h5a);  // First bank write
      drive(IDLE, {AR_WRITE_PREFIX, 2'b11}, 3'd3, 1'b1, '0);
      @(negedge clk);
      check_word("aext", 8'h80, aext);           // Not yet loaded
      aext_after(8'h5a);

      // Fill every bank of every context, scrambled ir order
      for (c = 0; c < 8; c++) begin
         drive(IDLE, UNIT_CTX_A, '0, 1'b0, 8'(c));
         for (b = 0; b < 8; b++) begin
            drive(IDLE, UNIT_MBN, 3'(b * 3), 1'b0, bank_fill(c, (b * 3) % 8));
         end
      end
      for (c = 0; c < 8; c++) begin
         drive(IDLE, UNIT_CTX_B, '0, 1'b0, 8'(c));
         for (b = 0; b < 8; b++) begin
            read_and_check(UNIT_MBN, 3'(b), bank_fill(c, b));
         end
         read_and_check(UNIT_MBP, 3'd6, bank_fill(c, 0));  // ir ignored
      end

      // Full context word, both codes, aliasing
      drive(IDLE, UNIT_CTX_A, '0, 1'b0, 8'hc3);
      read_and_check(UNIT_CTX_B, '0, 8'hc3);
      drive(IDLE, UNIT_CTX_B, '0, 1'b0, 8'h3c);
      read_and_check(UNIT_CTX_A, '0, 8'h3c);
      read_and_check(UNIT_MBN, 3'd1, bank_fill(4, 1));  // 3c aliases 4
      drive(IDLE, UNIT_MBN, 3'd1, 1'b0, 8'he7);
      drive(IDLE, UNIT_CTX_A, '0, 1'b0, 8'h04);
      read_and_check(UNIT_MBN, 3'd1, 8'he7);
      drive(IDLE, UNIT_CTX_A, '0, 1'b0, 8'h05);
      read_and_check(UNIT_MBN, 3'd1, bank_fill(5, 1));  // Other set untouched

      // AR bank from waddr, then from ir
      drive(IDLE, {AR_WRITE_PREFIX, 2'b10}, 3'd7, 1'b0, '0);
      aext_after(bank_fill(5, 2));
      drive(IDLE, {AR_WRITE_PREFIX, 2'b01}, 3'd6, 1'b1, '0);
      aext_after(bank_fill(5, 6));

      // Random mix, checked by the compare process
      for (n = 0; n < 400; n++) begin
         drive(pick_unit($random(seed)), pick_unit($random(seed)), 3'($random(seed)),
               1'($random(seed)), 8'($random(seed)));
         ram_rom = 1'($random(seed));
      end
      drive_idle();
      drive_idle();
      @(negedge clk);

      $display("Checks done, %0d errors", error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #((TEST_CYCLES + 100) * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + 100);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== hw/mbu_top.sv ====
//////////////////////////////
// One clock, no bus handshake; CTX_BITS set here
//////////////////////////////

`timescale 1ns/1ns

module mbu_top #(
   parameter int CTX_BITS = 3           // Context bits that select banks
) (
   input  logic               clk,
   input  logic               reset,
   input  mbu_pkg::unit_t     raddr,     // Read unit
   input  mbu_pkg::unit_t     waddr,     // Write unit
   input  mbu_pkg::bank_idx_t ir,        // ir[2:0]
   input  logic               ir_idx,    // AR bank from ir
   input  mbu_pkg::word_t     ibus_in,
   input  logic               ram_rom,
   output mbu_pkg::word_t     ibus_out,
   output logic               ibus_oe,
   output mbu_pkg::word_t     aext,
   output logic               war        // AR write strobe
);

   import mbu_pkg::*;

   mbu_strobes_t strobes;
   word_t        ctx;
   word_t        rd_data;
   word_t        ar_data;
   logic         enabled;

   //////////////////////////////
   // Instances
   //////////////////////////////

   mbu_decode u_decode (
      .raddr   (raddr),
      .waddr   (waddr),
      .ir      (ir),
      .ir_idx  (ir_idx),
      .strobes (strobes),
      .war     (war)
   );

   mbu_bank_file #(.CTX_BITS(CTX_BITS)) u_bank_file (
      .clk     (clk),
      .strobes (strobes),
      .ctx     (ctx),
      .ibus_in (ibus_in),
      .rd_data (rd_data),
      .ar_data (ar_data)
   );

   mbu_context #(.CTX_BITS(CTX_BITS)) u_context (
      .clk     (clk),
      .reset   (reset),
      .strobes (strobes),
      .ibus_in (ibus_in),
      .ctx     (ctx),
      .enabled (enabled)
   );

   mbu_output_mux u_output_mux (
      .clk      (clk),
      .reset    (reset),
      .strobes  (strobes),
      .rd_data  (rd_data),
      .ar_data  (ar_data),
      .ctx      (ctx),
      .enabled  (enabled),
      .ram_rom  (ram_rom),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .aext     (aext)
   );

endmodule

// ==== hw/mbu_output_mux.sv ====
//////////////////////////////
// ibus_out is zero when not driving; aext tracks ram_rom while disabled
//////////////////////////////

`timescale 1ns/1ns

module mbu_output_mux (
   input  logic                  clk,
   input  logic                  reset,
   input  mbu_pkg::mbu_strobes_t strobes,
   input  mbu_pkg::word_t        rd_data,   // Bank at rd_idx
   input  mbu_pkg::word_t        ar_data,   // Bank at ar_idx
   input  mbu_pkg::word_t        ctx,
   input  logic                  enabled,
   input  logic                  ram_rom,   // Front panel switch
   output mbu_pkg::word_t        ibus_out,
   output logic                  ibus_oe,
   output mbu_pkg::word_t        aext       // Upper address byte
);

   import mbu_pkg::*;

   word_t aext_default;   // Pull-up/pull-down value of the board

   //////////////////////////////
   // Bus read side
   //////////////////////////////

   // Combinational, valid in the cycle of the read select
   always_comb begin
      ibus_oe  = strobes.rd_mbn || strobes.rd_mbp || strobes.rd_ctx;
      ibus_out = '0;
      if (strobes.rd_ctx) begin
         ibus_out = ctx;
      end else if (strobes.rd_mbn || strobes.rd_mbp) begin
         ibus_out = rd_data;            // Same port for MBn and MBP
      end
   end

   //////////////////////////////
   // Address extension
   //////////////////////////////

   // ram_rom in bit 7, the rest zero
   always_comb begin
      aext_default                   = '0;
      aext_default[AEXT_RAM_ROM_BIT] = ram_rom;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         aext <= aext_default;
      end else if (!enabled) begin
         aext <= aext_default;          // Follows the switch until enabled
      end else if (strobes.wr_ar) begin
         aext <= ar_data;               // Holds until the next AR write
      end
   end

endmodule

// ==== mbu/mbu_context.sv ====
//////////////////////////////
// Enable sets on the first bank write, cleared only by reset
//////////////////////////////

`timescale 1ns/1ns

module mbu_context #(
   parameter int CTX_BITS = 3           // Low ctx bits seen by the bank file
) (
   input  logic                  clk,
   input  logic                  reset,
   input  mbu_pkg::mbu_strobes_t strobes,
   input  mbu_pkg::word_t        ibus_in,
   output mbu_pkg::word_t        ctx,      // Full word, readable back
   output logic                  enabled   // Unit drives real bank values
);

   import mbu_pkg::*;

   //////////////////////////////
   // Context register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ctx <= '0;                     // Context 0 after reset
      end else if (strobes.wr_ctx) begin
         ctx <= ibus_in;                // All 8 bits kept
      end
   end

   //////////////////////////////
   // Enable flip-flop
   //////////////////////////////

   // Any MBn or MBP write brings the unit out of its default state
   always_ff @(posedge clk) begin
      if (reset) begin
         enabled <= 1'b0;
      end else if (strobes.wr_mbn || strobes.wr_mbp) begin
         enabled <= 1'b1;               // Sticky until next reset
      end
   end

endmodule

// ==== mbu/mbu_bank_file.sv ====
//////////////////////////////
// Contents are not cleared by reset
// Only ctx[CTX_BITS-1:0] selects storage, higher contexts alias
//////////////////////////////

`timescale 1ns/1ns

module mbu_bank_file #(
   parameter int CTX_BITS = 3           // Context bits that pick a bank set
) (
   input  logic                  clk,
   input  mbu_pkg::mbu_strobes_t strobes,
   input  mbu_pkg::word_t        ctx,      // Current context, full word
   input  mbu_pkg::word_t        ibus_in,  // Write data
   output mbu_pkg::word_t        rd_data,  // Bank at rd_idx
   output mbu_pkg::word_t        ar_data   // Bank at ar_idx
);

   import mbu_pkg::*;

   //////////////////////////////
   // Storage
   //////////////////////////////

   localparam int DEPTH  = (2 ** CTX_BITS) * NUM_BANKS;
   localparam int ADDR_W = CTX_BITS + BANK_W;

   word_t mem [DEPTH];   // {context, bank} addressed

   logic [ADDR_W-1:0] rd_addr;   // Shared by the write port
   logic [ADDR_W-1:0] ar_addr;   // AR lookup port
   logic              wr_en;

   // Context on top, bank number below
   assign rd_addr = {ctx[CTX_BITS-1:0], strobes.rd_idx};
   assign ar_addr = {ctx[CTX_BITS-1:0], strobes.ar_idx};

   // MBn and MBP share one write port
   assign wr_en = strobes.wr_mbn || strobes.wr_mbp;

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Visible to reads in the next cycle
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[rd_addr] <= ibus_in;
      end
   end

   //////////////////////////////
   // Read ports
   //////////////////////////////

   // Asynchronous, like the SRAM on the board
   assign rd_data = mem[rd_addr];   // For the bus
   assign ar_data = mem[ar_addr];   // Old ctx if CTX is written this cycle

endmodule

// ==== hw/mbu_decode.sv ====
//////////////////////////////
// Pure decode, no clock; strobes are levels for the current cycle
//////////////////////////////

`timescale 1ns/1ns

module mbu_decode (
   input  mbu_pkg::unit_t       raddr,    // Read unit
   input  mbu_pkg::unit_t       waddr,    // Write unit
   input  mbu_pkg::bank_idx_t   ir,       // Bank number from the instruction
   input  logic                 ir_idx,   // AR lookup takes ir, not waddr
   output mbu_pkg::mbu_strobes_t strobes,
   output logic                 war       // Forwarded to the address register
);

   import mbu_pkg::*;

   logic ar_hit;    // waddr is one of the four AR writes
   logic mbp_any;   // MBP on either the read or the write side

   //////////////////////////////
   // Unit matching
   //////////////////////////////

   assign ar_hit  = (waddr[4:2] == AR_WRITE_PREFIX);
   assign mbp_any = (raddr == UNIT_MBP) || (waddr == UNIT_MBP);

   always_comb begin
      // Read side
      strobes.rd_mbn = (raddr == UNIT_MBN);
      strobes.rd_mbp = (raddr == UNIT_MBP);
      strobes.rd_ctx = (raddr == UNIT_CTX_A) || (raddr == UNIT_CTX_B);

      // Write side, same codes
      strobes.wr_mbn = (waddr == UNIT_MBN);
      strobes.wr_mbp = (waddr == UNIT_MBP);
      strobes.wr_ctx = (waddr == UNIT_CTX_A) || (waddr == UNIT_CTX_B);
      strobes.wr_ar  = ar_hit;

      //////////////////////////////
      // Bank indices
      //////////////////////////////

      // MBP is bank 0, MBn follows ir
      if (mbp_any) begin
         strobes.rd_idx = '0;
      end else begin
         strobes.rd_idx = ir;
      end

      // AR bank from ir or from the low write address bits
      if (ir_idx) begin
         strobes.ar_idx = ir;
      end else begin
         strobes.ar_idx = {1'b0, waddr[1:0]};   // Only banks 0..3 reachable
      end
   end

   assign war = ar_hit;   // Same as strobes.wr_ar

endmodule

// ==== common/mbu_pkg.sv ====
//////////////////////////////
// Unit codes and types for the MBU, 8-bit data on the low byte of the bus
//////////////////////////////

package mbu_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int WORD_W    = 8;    // Low byte of the internal bus
   localparam int UNIT_W    = 5;    // Control unit address
   localparam int BANK_W    = 3;    // Bank register number
   localparam int NUM_BANKS = 8;    // Bank registers per context

   // Bit of aext that carries the RAM/ROM switch while disabled
   localparam int AEXT_RAM_ROM_BIT = 7;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [UNIT_W-1:0] unit_t;
   typedef logic [BANK_W-1:0] bank_idx_t;

   //////////////////////////////
   // Unit addresses
   //////////////////////////////

   // Same codes for read and write units
   localparam unit_t UNIT_MBN   = 5'b11011;  // Bank register picked by ir
   localparam unit_t UNIT_MBP   = 5'b11100;  // Bank register 0
   localparam unit_t UNIT_CTX_A = 5'b11110;  // Context register
   localparam unit_t UNIT_CTX_B = 5'b11101;  // Context register, alias

   // waddr[4:2] for the four AR writes, waddr[1:0] picks the register
   localparam logic [2:0] AR_WRITE_PREFIX = 3'b001;

   //////////////////////////////
   // Decoded strobes
   //////////////////////////////

   // One-cycle levels, sampled on the rising clock edge
   typedef struct packed {
      logic      rd_mbn;    // MBn onto the bus
      logic      rd_mbp;    // MBP onto the bus
      logic      rd_ctx;    // CTX onto the bus
      logic      wr_mbn;    // Bus into MBn
      logic      wr_mbp;    // Bus into MBP
      logic      wr_ctx;    // Bus into CTX
      logic      wr_ar;     // Any of the four AR writes
      bank_idx_t rd_idx;    // Bank for MBn/MBP access
      bank_idx_t ar_idx;    // Bank for the AR lookup
   } mbu_strobes_t;

endpackage
